// File: Makefile
# Verilator build and run of the fetch front-end testbench.

VERILATOR ?= verilator
TOP       ?= fe_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_STR  ?= Test passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/fe_fault_check.sv
// ======================================
// fe_fault_check
// classifies a stage-1 lookup into an
// instruction or a single exception.
// ======================================

`timescale 1ns/1ps
`default_nettype none

module fe_fault_check (
  input  logic                  itlb_hit_i,
  input  fe_pkg::tlb_entry_s    entry_i,
  input  fe_pkg::ptag_t         ptag_i,
  input  fe_pkg::priv_e         priv_i,
  input  logic                  translation_en_i,
  input  logic                  tag_hit_i,
  input  fe_pkg::instr_t        instr_i,
  output fe_pkg::fetch_result_s result_o
);

  logic priv_fault, exe_fault, page_fault, access_fault;

  // supervisor may not run user pages, user may only run user pages.
  assign priv_fault   = ((priv_i == fe_pkg::e_priv_s) & entry_i.u)
                      | ((priv_i == fe_pkg::e_priv_u) & ~entry_i.u);
  assign exe_fault    = ~entry_i.x;
  assign page_fault   = translation_en_i & (priv_fault | exe_fault);
  assign access_fault = ptag_i[fe_pkg::io_ptag_bit];

  always_comb begin
    result_o.instr = instr_i;
    if (translation_en_i && !itlb_hit_i) begin
      result_o.qtype = fe_pkg::e_q_itlb_miss;
    end else if (page_fault) begin
      result_o.qtype = fe_pkg::e_q_page_fault;
    end else if (access_fault) begin
      result_o.qtype = fe_pkg::e_q_access_fault;
    end else if (!tag_hit_i) begin
      result_o.qtype = fe_pkg::e_q_icache_miss;
    end else begin
      result_o.qtype = fe_pkg::e_q_instr;
    end
  end

endmodule

`default_nettype wire

// File: hw/fe_icache.sv
// ======================================
// fe_icache
// sixteen-line direct-mapped VIPT
// instruction cache, one word per line,
// with fill port, fence and registered
// lookup.
// ======================================

`timescale 1ns/1ps
`default_nettype none

module fe_icache (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  fe_pkg::fetch_cmd_s   fetch_cmd_i,
  input  logic                 fetch_v_i,
  input  fe_pkg::ptag_t        ptag_i,
  input  fe_pkg::icache_fill_s fill_i,
  input  logic                 fill_v_i,
  output logic                 fill_ready_o,
  output logic                 tag_hit_o,
  output fe_pkg::instr_t       instr_o
);

  fe_pkg::itag_t                  tag_mem  [fe_pkg::icache_sets];
  fe_pkg::instr_t                 data_mem [fe_pkg::icache_sets];
  logic [fe_pkg::icache_sets-1:0] line_v_r;
  fe_pkg::icache_idx_t            rd_idx, wr_idx;
  fe_pkg::itag_t                  tag_r;
  logic                           lv_r;
  logic [fe_pkg::tag_ofs_w-1:0]   ofs_r;
  logic                           lookup_v, fence_v, fill_acc;

  assign lookup_v = fetch_v_i & (fetch_cmd_i.op == fe_pkg::e_op_fetch);
  assign fence_v  = fetch_v_i & (fetch_cmd_i.op == fe_pkg::e_op_icache_fence);

  // the arrays have one port, so a fill waits out any lookup or fence.
  assign fill_ready_o = ~(lookup_v | fence_v);
  assign fill_acc     = fill_v_i & fill_ready_o;

  assign rd_idx = fetch_cmd_i.vaddr[fe_pkg::icache_idx_lsb +: fe_pkg::icache_idx_w];
  assign wr_idx = fill_i.paddr[fe_pkg::icache_idx_lsb +: fe_pkg::icache_idx_w];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      line_v_r <= '0;
    end else if (fence_v) begin
      line_v_r <= '0;
    end else if (fill_acc) begin
      line_v_r[wr_idx] <= 1'b1;
    end
  end

  // ======================================
  // arrays and stage-1 registers
  // ======================================

  always_ff @(posedge clk_i) begin
    if (fill_acc) begin
      tag_mem[wr_idx]  <= fill_i.paddr[fe_pkg::paddr_w-1 -: fe_pkg::itag_w];
      data_mem[wr_idx] <= fill_i.instr;
    end
    if (lookup_v) begin
      tag_r   <= tag_mem[rd_idx];
      lv_r    <= line_v_r[rd_idx];
      instr_o <= data_mem[rd_idx];
      ofs_r   <= fetch_cmd_i.vaddr[fe_pkg::page_ofs_w-1 -: fe_pkg::tag_ofs_w];
    end
  end

  // the low tag bits sit inside the page offset and are untranslated.
  assign tag_hit_o = lv_r & (tag_r == {ptag_i, ofs_r});

endmodule

`default_nettype wire

// File: hw/fe_itlb.sv
// ======================================
// fe_itlb
// four-entry fully associative ITLB with
// fill, fence and a registered lookup.
// ======================================

`timescale 1ns/1ps
`default_nettype none

module fe_itlb (
  input  logic               clk_i,
  input  logic               reset_i,
  input  fe_pkg::fetch_cmd_s fetch_cmd_i,
  input  logic               fetch_v_i,
  input  logic               translation_en_i,
  output fe_pkg::ptag_t      ptag_o,
  output logic               hit_o,
  output fe_pkg::tlb_entry_s entry_o
);

  fe_pkg::vtag_t                 vtag_r [fe_pkg::itlb_els];
  fe_pkg::tlb_entry_s            tlb_r  [fe_pkg::itlb_els];
  logic [fe_pkg::itlb_els-1:0]   v_r;
  logic [fe_pkg::itlb_els-1:0]   look_match, fill_match;
  fe_pkg::itlb_ptr_t             victim_r, fill_idx, match_idx;
  fe_pkg::vtag_t                 look_vtag;
  logic                          look_hit, fill_hit;
  logic                          lookup_v, fill_v, fence_v;

  assign lookup_v  = fetch_v_i & (fetch_cmd_i.op == fe_pkg::e_op_fetch);
  assign fill_v    = fetch_v_i & (fetch_cmd_i.op == fe_pkg::e_op_itlb_fill);
  assign fence_v   = fetch_v_i & (fetch_cmd_i.op == fe_pkg::e_op_itlb_fence);
  assign look_vtag = fetch_cmd_i.vaddr[fe_pkg::vaddr_w-1 -: fe_pkg::vtag_w];

  // lowest matching entry wins. a fill of a mapped vtag rewrites it in place.
  always_comb begin
    match_idx = '0;
    fill_idx  = victim_r;
    for (int i = fe_pkg::itlb_els - 1; i >= 0; i--) begin
      look_match[i] = v_r[i] & (vtag_r[i] == look_vtag);
      fill_match[i] = v_r[i] & (vtag_r[i] == fetch_cmd_i.vtag);
      if (look_match[i]) match_idx = fe_pkg::itlb_ptr_t'(i);
      if (fill_match[i]) fill_idx = fe_pkg::itlb_ptr_t'(i);
    end
  end

  assign look_hit = |look_match;
  assign fill_hit = |fill_match;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_r      <= '0;
      victim_r <= '0;
    end else if (fence_v) begin
      v_r <= '0;
    end else if (fill_v) begin
      v_r[fill_idx] <= 1'b1;
      if (!fill_hit) begin
        victim_r <= victim_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_v) begin
      vtag_r[fill_idx] <= fetch_cmd_i.vtag;
      tlb_r[fill_idx]  <= fetch_cmd_i.entry;
    end
    if (lookup_v) begin
      if (translation_en_i) begin
        hit_o   <= look_hit;
        ptag_o  <= tlb_r[match_idx].ptag;
        entry_o <= tlb_r[match_idx];
      end else begin
        // bare mode maps the page straight through.
        hit_o   <= 1'b1;
        ptag_o  <= look_vtag;
        entry_o <= '{ptag: look_vtag, u: 1'b0, x: 1'b1};
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/fe_pc_gen.sv
// ======================================
// fe_pc_gen
// front-end control. tracks pc, privilege
// and translation mode, arbitrates the
// issue slot, builds queue entries and
// handles replay and exception stall.
// ======================================

`timescale 1ns/1ps
`default_nettype none

module fe_pc_gen (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  fe_pkg::fe_cmd_s       fe_cmd_i,
  input  logic                  fe_cmd_v_i,
  output logic                  fe_cmd_ready_o,
  output fe_pkg::fe_queue_s     fe_queue_o,
  output logic                  fe_queue_v_o,
  input  logic                  fe_queue_ready_i,
  output fe_pkg::fetch_cmd_s    fetch_cmd_o,
  output logic                  fetch_v_o,
  output fe_pkg::priv_e         priv_o,
  output logic                  translation_en_o,
  output logic                  poison_o,
  input  fe_pkg::fetch_result_s result_i
);

  fe_pkg::pc_gen_state_e state_r, state_n;
  fe_pkg::vaddr_t        pc_r, pc_n, s1_pc_r;
  logic                  s1_v_r, s1_v_n;
  logic                  cmd_acc, redirect_v, fetch_issue;
  logic                  q_drop, q_exc;

  // commands never wait, they simply take the issue slot.
  assign fe_cmd_ready_o = 1'b1;
  assign cmd_acc        = fe_cmd_v_i & fe_cmd_ready_o;
  assign redirect_v     = cmd_acc & (fe_cmd_i.op == fe_pkg::e_cmd_redirect);
  assign fetch_issue    = (state_r == fe_pkg::e_run) & ~cmd_acc;

  // a redirect kills the stage-1 item in the same cycle.
  assign fe_queue_v_o = s1_v_r & ~redirect_v;
  assign q_drop       = fe_queue_v_o & ~fe_queue_ready_i;
  assign q_exc        = fe_queue_v_o & fe_queue_ready_i
                      & (result_i.qtype != fe_pkg::e_q_instr);
  assign poison_o     = redirect_v | q_drop | q_exc;
  assign s1_v_n       = fetch_issue & ~poison_o;

  assign fe_queue_o = '{qtype: result_i.qtype, pc: s1_pc_r, instr: result_i.instr};

  // ======================================
  // issue slot
  // ======================================

  always_comb begin
    fetch_cmd_o.op    = fe_pkg::e_op_fetch;
    fetch_cmd_o.vaddr = pc_r;
    fetch_cmd_o.vtag  = fe_cmd_i.vtag;
    fetch_cmd_o.entry = fe_cmd_i.entry;
    fetch_v_o         = fetch_issue;
    if (cmd_acc) begin
      case (fe_cmd_i.op)
        fe_pkg::e_cmd_itlb_fill: begin
          fetch_cmd_o.op = fe_pkg::e_op_itlb_fill;
          fetch_v_o      = 1'b1;
        end
        fe_pkg::e_cmd_itlb_fence: begin
          fetch_cmd_o.op = fe_pkg::e_op_itlb_fence;
          fetch_v_o      = 1'b1;
        end
        fe_pkg::e_cmd_icache_fence: begin
          fetch_cmd_o.op = fe_pkg::e_op_icache_fence;
          fetch_v_o      = 1'b1;
        end
        default: begin
          fetch_v_o = 1'b0;
        end
      endcase
    end
  end

  always_comb begin
    state_n = state_r;
    pc_n    = pc_r;
    if (redirect_v) begin
      state_n = fe_pkg::e_run;
      pc_n    = fe_cmd_i.pc;
    end else if (q_drop) begin
      // refetch the dropped item, the younger one is already poisoned.
      pc_n = s1_pc_r;
    end else begin
      if (fetch_issue) begin
        pc_n = pc_r + 32'd4;
      end
      if (q_exc) begin
        state_n = fe_pkg::e_stall;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r          <= fe_pkg::e_idle;
      s1_v_r           <= 1'b0;
      priv_o           <= fe_pkg::e_priv_s;
      translation_en_o <= 1'b0;
    end else begin
      state_r <= state_n;
      s1_v_r  <= s1_v_n;
      if (redirect_v) begin
        priv_o           <= fe_cmd_i.priv;
        translation_en_o <= fe_cmd_i.translation_en;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    pc_r <= pc_n;
    if (fetch_issue) begin
      s1_pc_r <= pc_r;
    end
  end

endmodule

`default_nettype wire

// File: hw/fe_pkg.sv
// ======================================
// fe package
// shared widths, vector types, command and
// queue structs and the enums of the
// instruction-fetch front end.
// ======================================

`default_nettype none

package fe_pkg;

  localparam int vaddr_w        = 32;
  localparam int paddr_w        = 32;
  localparam int page_ofs_w     = 12;
  localparam int vtag_w         = vaddr_w - page_ofs_w;
  localparam int ptag_w         = paddr_w - page_ofs_w;
  localparam int itag_w         = 26;
  localparam int tag_ofs_w      = itag_w - ptag_w;
  localparam int instr_w        = 32;
  localparam int itlb_els       = 4;
  localparam int itlb_ptr_w     = $clog2(itlb_els);
  localparam int icache_sets    = 16;
  localparam int icache_idx_w   = $clog2(icache_sets);
  localparam int icache_idx_lsb = 2;
  // physical pages with this bit set belong to the I/O region.
  localparam int io_ptag_bit    = ptag_w - 1;

  typedef logic [vaddr_w-1:0]      vaddr_t;
  typedef logic [paddr_w-1:0]      paddr_t;
  typedef logic [vtag_w-1:0]       vtag_t;
  typedef logic [ptag_w-1:0]       ptag_t;
  typedef logic [itag_w-1:0]       itag_t;
  typedef logic [instr_w-1:0]      instr_t;
  typedef logic [itlb_ptr_w-1:0]   itlb_ptr_t;
  typedef logic [icache_idx_w-1:0] icache_idx_t;

  typedef enum logic [1:0] {
    e_priv_u = 2'b00,
    e_priv_s = 2'b01
  } priv_e;

  typedef enum logic [1:0] {
    e_cmd_redirect,
    e_cmd_itlb_fill,
    e_cmd_itlb_fence,
    e_cmd_icache_fence
  } fe_cmd_op_e;

  typedef enum logic [1:0] {
    e_op_fetch,
    e_op_itlb_fill,
    e_op_itlb_fence,
    e_op_icache_fence
  } fetch_op_e;

  typedef enum logic [2:0] {
    e_q_instr,
    e_q_itlb_miss,
    e_q_page_fault,
    e_q_access_fault,
    e_q_icache_miss
  } fe_queue_type_e;

  typedef enum logic [1:0] {
    e_idle,
    e_run,
    e_stall
  } pc_gen_state_e;

  typedef struct packed {
    ptag_t ptag;
    logic  u;
    logic  x;
  } tlb_entry_s;

  // ======================================
  // interface payloads
  // ======================================

  typedef struct packed {
    fe_cmd_op_e op;
    vaddr_t     pc;
    priv_e      priv;
    logic       translation_en;
    vtag_t      vtag;
    tlb_entry_s entry;
  } fe_cmd_s;

  typedef struct packed {
    fetch_op_e  op;
    vaddr_t     vaddr;
    vtag_t      vtag;
    tlb_entry_s entry;
  } fetch_cmd_s;

  typedef struct packed {
    fe_queue_type_e qtype;
    vaddr_t         pc;
    instr_t         instr;
  } fe_queue_s;

  typedef struct packed {
    paddr_t paddr;
    instr_t instr;
  } icache_fill_s;

  typedef struct packed {
    fe_queue_type_e qtype;
    instr_t         instr;
  } fetch_result_s;

endpackage

`default_nettype wire

// File: hw/fe_top.sv
// ======================================
// fe_top
// instruction-fetch front end. joins the
// PC generator, ITLB, I-cache and fault
// checker.
// ======================================

`timescale 1ns/1ps
`default_nettype none

module fe_top (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  fe_pkg::fe_cmd_s      fe_cmd_i,
  input  logic                 fe_cmd_v_i,
  output logic                 fe_cmd_ready_o,
  output fe_pkg::fe_queue_s    fe_queue_o,
  output logic                 fe_queue_v_o,
  input  logic                 fe_queue_ready_i,
  input  fe_pkg::icache_fill_s fill_i,
  input  logic                 fill_v_i,
  output logic                 fill_ready_o
);

  fe_pkg::fetch_cmd_s    fetch_cmd;
  logic                  fetch_v;
  fe_pkg::priv_e         priv;
  logic                  translation_en;
  fe_pkg::ptag_t         itlb_ptag;
  logic                  itlb_hit;
  fe_pkg::tlb_entry_s    itlb_entry;
  logic                  tag_hit;
  fe_pkg::instr_t        instr;
  fe_pkg::fetch_result_s result;

  fe_pc_gen u_pc_gen (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .fe_cmd_i         (fe_cmd_i),
    .fe_cmd_v_i       (fe_cmd_v_i),
    .fe_cmd_ready_o   (fe_cmd_ready_o),
    .fe_queue_o       (fe_queue_o),
    .fe_queue_v_o     (fe_queue_v_o),
    .fe_queue_ready_i (fe_queue_ready_i),
    .fetch_cmd_o      (fetch_cmd),
    .fetch_v_o        (fetch_v),
    .priv_o           (priv),
    .translation_en_o (translation_en),
    .poison_o         (),
    .result_i         (result)
  );

  fe_itlb u_itlb (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .fetch_cmd_i      (fetch_cmd),
    .fetch_v_i        (fetch_v),
    .translation_en_i (translation_en),
    .ptag_o           (itlb_ptag),
    .hit_o            (itlb_hit),
    .entry_o          (itlb_entry)
  );

  fe_icache u_icache (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .fetch_cmd_i  (fetch_cmd),
    .fetch_v_i    (fetch_v),
    .ptag_i       (itlb_ptag),
    .fill_i       (fill_i),
    .fill_v_i     (fill_v_i),
    .fill_ready_o (fill_ready_o),
    .tag_hit_o    (tag_hit),
    .instr_o      (instr)
  );

  fe_fault_check u_fault_check (
    .itlb_hit_i       (itlb_hit),
    .entry_i          (itlb_entry),
    .ptag_i           (itlb_ptag),
    .priv_i           (priv),
    .translation_en_i (translation_en),
    .tag_hit_i        (tag_hit),
    .instr_i          (instr),
    .result_o         (result)
  );

endmodule

`default_nettype wire

// File: src.f
hw/fe_pkg.sv
hw/fe_itlb.sv
hw/fe_icache.sv
hw/fe_fault_check.sv
hw/fe_pc_gen.sv
hw/fe_top.sv
verif/fe_chk.sv
verif/fe_tb.sv

// File: verif/fe_chk.sv
// ========================================
// fe_chk
// concurrent assertions on the command,
// queue and fill handshakes of fe_top.
// ========================================

`timescale 1ns/1ps
`default_nettype none

module fe_chk (
  input logic               clk_i,
  input logic               reset_i,
  input fe_pkg::fe_cmd_s    fe_cmd_i,
  input logic               fe_cmd_v_i,
  input logic               cmd_ready_i,
  input logic               queue_v_i,
  input logic               fill_ready_i,
  input fe_pkg::fetch_cmd_s fetch_cmd_i,
  input logic               fetch_v_i
);

  int unsigned err_reset    = 0;
  int unsigned err_ready    = 0;
  int unsigned err_redirect = 0;
  int unsigned err_fill     = 0;
  int unsigned fail_cnt;
  logic        redirect_acc;
  logic        port_busy;

  assign fail_cnt     = err_reset + err_ready + err_redirect + err_fill;
  assign redirect_acc = fe_cmd_v_i & cmd_ready_i & (fe_cmd_i.op == fe_pkg::e_cmd_redirect);
  // lookups and the cache fence both use the single array port.
  assign port_busy    = fetch_v_i & ((fetch_cmd_i.op == fe_pkg::e_op_fetch)
                      | (fetch_cmd_i.op == fe_pkg::e_op_icache_fence));

  a_queue_idle_in_reset: assert property (@(posedge clk_i) reset_i |=> !queue_v_i)
    else begin
      $error("queue valid high during or right after reset");
      err_reset++;
    end

  a_cmd_ready: assert property (@(posedge clk_i) disable iff (reset_i) cmd_ready_i)
    else begin
      $error("command ready low out of reset");
      err_ready++;
    end

  a_redirect_gap: assert property (@(posedge clk_i) disable iff (reset_i)
                                   redirect_acc |=> !queue_v_i)
    else begin
      $error("queue valid in the cycle after a redirect");
      err_redirect++;
    end

  a_fill_blocked: assert property (@(posedge clk_i) disable iff (reset_i)
                                   port_busy |-> !fill_ready_i)
    else begin
      $error("fill ready high while the array port is busy");
      err_fill++;
    end

endmodule

bind fe_top fe_chk u_fe_chk (
  .clk_i        (clk_i),
  .reset_i      (reset_i),
  .fe_cmd_i     (fe_cmd_i),
  .fe_cmd_v_i   (fe_cmd_v_i),
  .cmd_ready_i  (fe_cmd_ready_o),
  .queue_v_i    (fe_queue_v_o),
  .fill_ready_i (fill_ready_o),
  .fetch_cmd_i  (fetch_cmd),
  .fetch_v_i    (fetch_v)
);

`default_nettype wire

// File: verif/fe_tb.sv
// ========================================
// fe_tb
// table-driven testbench for the fetch
// front end. a model of the cache lines
// and ITLB entries predicts every queue
// entry that the back end accepts.
// ========================================

`timescale 1ns/1ps
`default_nettype none

module fe_tb;

  localparam int wait_limit   = 200;
  localparam int quiet_cycles = 8;
  localparam int max_rows     = 64;

  typedef struct packed {
    logic                   is_fill;
    fe_pkg::fe_cmd_s        cmd;
    fe_pkg::icache_fill_s   fill;
    logic [7:0]             n_entries;
    fe_pkg::fe_queue_type_e end_type;
  } row_s;

  logic                 clk_i;
  logic                 reset_i;
  fe_pkg::fe_cmd_s      fe_cmd_i;
  logic                 fe_cmd_v_i;
  logic                 fe_cmd_ready_o;
  fe_pkg::fe_queue_s    fe_queue_o;
  logic                 fe_queue_v_o;
  logic                 fe_queue_ready_i;
  fe_pkg::icache_fill_s fill_i;
  logic                 fill_v_i;
  logic                 fill_ready_o;

  row_s rows [max_rows];
  int   n_rows;

  // reference state of the front end.
  fe_pkg::itag_t      m_tag    [fe_pkg::icache_sets];
  fe_pkg::instr_t     m_data   [fe_pkg::icache_sets];
  logic               m_line_v [fe_pkg::icache_sets];
  fe_pkg::vtag_t      m_vtag   [fe_pkg::itlb_els];
  fe_pkg::tlb_entry_s m_tlb    [fe_pkg::itlb_els];
  logic               m_tlb_v  [fe_pkg::itlb_els];
  int                 m_victim;
  fe_pkg::priv_e      m_priv;
  logic               m_trans;
  logic [31:0]        lcg_state;

  fe_top u_fe_top (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .fe_cmd_i         (fe_cmd_i),
    .fe_cmd_v_i       (fe_cmd_v_i),
    .fe_cmd_ready_o   (fe_cmd_ready_o),
    .fe_queue_o       (fe_queue_o),
    .fe_queue_v_o     (fe_queue_v_o),
    .fe_queue_ready_i (fe_queue_ready_i),
    .fill_i           (fill_i),
    .fill_v_i         (fill_v_i),
    .fill_ready_o     (fill_ready_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ========================================
  // reporting and compares
  // ========================================

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_queue_type(input string name, input fe_pkg::fe_queue_type_e got,
                                  input fe_pkg::fe_queue_type_e exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_pc(input string name, input fe_pkg::vaddr_t got,
                          input fe_pkg::vaddr_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_instr(input string name, input fe_pkg::instr_t got,
                             input fe_pkg::instr_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic fe_pkg::instr_t fill_word(input fe_pkg::paddr_t a);
    return (a * 32'h9e37_79b1) ^ 32'h0000_0013;
  endfunction

  // ========================================
  // reference model
  // ========================================

  task automatic reset_model();
    for (int i = 0; i < fe_pkg::icache_sets; i++) begin
      m_line_v[i] = 1'b0;
    end
    for (int i = 0; i < fe_pkg::itlb_els; i++) begin
      m_tlb_v[i] = 1'b0;
    end
    m_victim = 0;
    m_priv   = fe_pkg::e_priv_s;
    m_trans  = 1'b0;
  endtask

  task automatic model_tlb_fill(input fe_pkg::vtag_t v, input fe_pkg::tlb_entry_s e);
    int slot;
    slot = -1;
    for (int i = 0; i < fe_pkg::itlb_els; i++) begin
      if (slot < 0 && m_tlb_v[i] && m_vtag[i] == v) slot = i;
    end
    // a page that is already mapped keeps its slot.
    if (slot < 0) begin
      slot     = m_victim;
      m_victim = (m_victim + 1) % fe_pkg::itlb_els;
    end
    m_vtag[slot]  = v;
    m_tlb[slot]   = e;
    m_tlb_v[slot] = 1'b1;
  endtask

  task automatic update_model_cmd(input fe_pkg::fe_cmd_s c);
    case (c.op)
      fe_pkg::e_cmd_redirect: begin
        m_priv  = c.priv;
        m_trans = c.translation_en;
      end
      fe_pkg::e_cmd_itlb_fill: model_tlb_fill(c.vtag, c.entry);
      fe_pkg::e_cmd_itlb_fence: begin
        for (int i = 0; i < fe_pkg::itlb_els; i++) m_tlb_v[i] = 1'b0;
      end
      default: begin
        for (int i = 0; i < fe_pkg::icache_sets; i++) m_line_v[i] = 1'b0;
      end
    endcase
  endtask

  task automatic update_model_fill(input fe_pkg::icache_fill_s f);
    m_tag[f.paddr[5:2]]    = f.paddr[31:6];
    m_data[f.paddr[5:2]]   = f.instr;
    m_line_v[f.paddr[5:2]] = 1'b1;
  endtask

  function automatic fe_pkg::fe_queue_type_e model_lookup(input fe_pkg::vaddr_t pc,
                                                          output fe_pkg::instr_t instr);
    fe_pkg::ptag_t          ptag;
    fe_pkg::tlb_entry_s     ent;
    fe_pkg::fe_queue_type_e kind;
    logic                   hit;
    ptag  = pc[31:12];
    ent   = '{ptag: pc[31:12], u: 1'b0, x: 1'b1};
    hit   = ~m_trans;
    instr = '0;
    for (int i = 0; i < fe_pkg::itlb_els; i++) begin
      if (m_trans && !hit && m_tlb_v[i] && m_vtag[i] == pc[31:12]) begin
        hit = 1'b1;
        ent = m_tlb[i];
      end
    end
    if (m_trans) ptag = ent.ptag;
    if (!hit) begin
      kind = fe_pkg::e_q_itlb_miss;
    end else if (m_trans && (((m_priv == fe_pkg::e_priv_s) && ent.u)
                 || ((m_priv == fe_pkg::e_priv_u) && !ent.u) || !ent.x)) begin
      kind = fe_pkg::e_q_page_fault;
    end else if (ptag[19]) begin
      kind = fe_pkg::e_q_access_fault;
    end else if (m_line_v[pc[5:2]] && m_tag[pc[5:2]] == {ptag, pc[11:6]}) begin
      kind  = fe_pkg::e_q_instr;
      instr = m_data[pc[5:2]];
    end else begin
      kind = fe_pkg::e_q_icache_miss;
    end
    return kind;
  endfunction

  // ========================================
  // stimulus table
  // ========================================

  task automatic push_row(input row_s r);
    rows[n_rows] = r;
    n_rows++;
  endtask

  task automatic add_fill(input fe_pkg::paddr_t a, input fe_pkg::instr_t w);
    row_s r;
    r            = '0;
    r.is_fill    = 1'b1;
    r.fill.paddr = a;
    r.fill.instr = w;
    push_row(r);
  endtask

  task automatic add_redirect(input fe_pkg::vaddr_t pc, input fe_pkg::priv_e p, input logic t,
                              input int n, input fe_pkg::fe_queue_type_e e);
    row_s r;
    r                    = '0;
    r.cmd.op             = fe_pkg::e_cmd_redirect;
    r.cmd.pc             = pc;
    r.cmd.priv           = p;
    r.cmd.translation_en = t;
    r.n_entries          = 8'(n);
    r.end_type           = e;
    push_row(r);
  endtask

  task automatic add_tlb_fill(input fe_pkg::vtag_t v, input fe_pkg::ptag_t p,
                              input logic u, input logic x);
    row_s r;
    r           = '0;
    r.cmd.op    = fe_pkg::e_cmd_itlb_fill;
    r.cmd.vtag  = v;
    r.cmd.entry = '{ptag: p, u: u, x: x};
    push_row(r);
  endtask

  task automatic add_fence(input fe_pkg::fe_cmd_op_e op);
    row_s r;
    r        = '0;
    r.cmd.op = op;
    push_row(r);
  endtask

  task automatic build_table();
    n_rows = 0;
    for (int i = 0; i < 6; i++) begin
      add_fill(32'h0000_1000 + i * 4, fill_word(32'h0000_1000 + i * 4));
    end
    add_redirect(32'h0000_1000, fe_pkg::e_priv_s, 1'b0, 7, fe_pkg::e_q_icache_miss);
    add_redirect(32'h0000_1008, fe_pkg::e_priv_s, 1'b0, 5, fe_pkg::e_q_icache_miss);
    add_fill(32'h0000_1018, fill_word(32'h0000_1018));
    add_redirect(32'h0000_1018, fe_pkg::e_priv_s, 1'b0, 2, fe_pkg::e_q_icache_miss);
    // translated fetches through the same physical lines.
    add_redirect(32'h4000_1000, fe_pkg::e_priv_s, 1'b1, 1, fe_pkg::e_q_itlb_miss);
    add_tlb_fill(20'h40001, 20'h00001, 1'b0, 1'b1);
    add_redirect(32'h4000_1000, fe_pkg::e_priv_s, 1'b1, 8, fe_pkg::e_q_icache_miss);
    add_redirect(32'h4000_1000, fe_pkg::e_priv_u, 1'b1, 1, fe_pkg::e_q_page_fault);
    add_tlb_fill(20'h40002, 20'h00001, 1'b0, 1'b0);
    add_redirect(32'h4000_2004, fe_pkg::e_priv_s, 1'b1, 1, fe_pkg::e_q_page_fault);
    add_tlb_fill(20'h40003, 20'h80001, 1'b0, 1'b1);
    add_redirect(32'h4000_3000, fe_pkg::e_priv_s, 1'b1, 1, fe_pkg::e_q_access_fault);
    add_tlb_fill(20'h40004, 20'h00001, 1'b1, 1'b1);
    add_redirect(32'h4000_4010, fe_pkg::e_priv_u, 1'b1, 4, fe_pkg::e_q_icache_miss);
    // the fifth page evicts the first one.
    add_tlb_fill(20'h40005, 20'h00001, 1'b0, 1'b1);
    add_redirect(32'h4000_1000, fe_pkg::e_priv_s, 1'b1, 1, fe_pkg::e_q_itlb_miss);
    add_redirect(32'h4000_5008, fe_pkg::e_priv_s, 1'b1, 6, fe_pkg::e_q_icache_miss);
    add_fence(fe_pkg::e_cmd_itlb_fence);
    add_redirect(32'h4000_4010, fe_pkg::e_priv_u, 1'b1, 1, fe_pkg::e_q_itlb_miss);
    add_fence(fe_pkg::e_cmd_icache_fence);
    add_redirect(32'h0000_1000, fe_pkg::e_priv_s, 1'b0, 1, fe_pkg::e_q_icache_miss);
    add_fill(32'h0000_1000, ~fill_word(32'h0000_1000));
    add_redirect(32'h0000_1000, fe_pkg::e_priv_s, 1'b0, 2, fe_pkg::e_q_icache_miss);
  endtask

  // ========================================
  // drivers
  // ========================================

  task automatic apply_fill(input fe_pkg::icache_fill_s f);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    fill_i   = f;
    fill_v_i = 1'b1;
    #1;
    while (!fill_ready_o) begin
      cycles++;
      if (cycles > wait_limit) abort_run("timed out waiting for the fill port to be ready");
      @(negedge clk_i);
      #1;
    end
    @(posedge clk_i);
    update_model_fill(f);
    @(negedge clk_i);
    fill_v_i = 1'b0;
  endtask

  task automatic apply_cmd(input fe_pkg::fe_cmd_s c);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    fe_cmd_i   = c;
    fe_cmd_v_i = 1'b1;
    #1;
    while (!fe_cmd_ready_o) begin
      cycles++;
      if (cycles > wait_limit) abort_run("timed out waiting for command ready");
      @(negedge clk_i);
      #1;
    end
    @(posedge clk_i);
    update_model_cmd(c);
    @(negedge clk_i);
    fe_cmd_v_i = 1'b0;
  endtask

  task automatic collect_stream(input fe_pkg::vaddr_t start_pc, input int n,
                                input fe_pkg::fe_queue_type_e end_type);
    fe_pkg::vaddr_t         exp_pc;
    fe_pkg::instr_t         exp_instr;
    fe_pkg::fe_queue_type_e exp_type;
    int                     got;
    int                     idle;
    logic                   rdy;
    exp_pc = start_pc;
    got    = 0;
    idle   = 0;
    while (got < n) begin
      lcg_state        = lcg_next(lcg_state);
      rdy              = (lcg_state[19:16] < 4'd11);
      fe_queue_ready_i = rdy;
      #1;
      if (fe_queue_v_o && rdy) begin
        exp_type = model_lookup(exp_pc, exp_instr);
        check_pc("fe_queue_o.pc", fe_queue_o.pc, exp_pc);
        check_queue_type("fe_queue_o.qtype", fe_queue_o.qtype, exp_type);
        if (exp_type == fe_pkg::e_q_instr) begin
          check_instr("fe_queue_o.instr", fe_queue_o.instr, exp_instr);
        end
        got++;
        if (got == n) begin
          check_queue_type("fe_queue_o.qtype", fe_queue_o.qtype, end_type);
        end else begin
          check_queue_type("fe_queue_o.qtype", fe_queue_o.qtype, fe_pkg::e_q_instr);
        end
        exp_pc = exp_pc + 32'd4;
        idle   = 0;
      end else begin
        idle++;
        if (idle > wait_limit) abort_run("timed out waiting for a fetch-queue entry");
      end
      @(negedge clk_i);
    end
    // fetch must stay stopped after the exception.
    fe_queue_ready_i = 1'b1;
    for (int i = 0; i < quiet_cycles; i++) begin
      #1;
      if (fe_queue_v_o) abort_run("a queue entry followed the exception that ended the stream");
      @(negedge clk_i);
    end
  endtask

  task automatic apply_row(input row_s r);
    if (r.is_fill) begin
      apply_fill(r.fill);
    end else begin
      apply_cmd(r.cmd);
      if (r.cmd.op == fe_pkg::e_cmd_redirect) begin
        collect_stream(r.cmd.pc, int'(r.n_entries), r.end_type);
      end
    end
  endtask

  initial begin
    reset_i          = 1'b1;
    fe_cmd_i         = '0;
    fe_cmd_v_i       = 1'b0;
    fe_queue_ready_i = 1'b0;
    fill_i           = '0;
    fill_v_i         = 1'b0;
    lcg_state        = 32'd29420;
    reset_model();
    build_table();
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    for (int r = 0; r < n_rows; r++) begin
      apply_row(rows[r]);
    end
    if (u_fe_top.u_fe_chk.fail_cnt == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      abort_run("a bound assertion on the front-end handshakes failed");
    end
  end

endmodule

`default_nettype wire
